// ==== include/valu_defines.svh ====
`ifndef VALU_DEFINES_SVH
`define VALU_DEFINES_SVH

// ------------------------------------------------
// vector geometry
// ------------------------------------------------

// lanes per vector
`define VALU_NUM_ELEMS 4

// bits per element
// accumulators and products hold twice as many
`define VALU_ELEM_W 16

// ------------------------------------------------
// pipeline depths
// ------------------------------------------------

// register stages behind the operand register
`define VALU_MULT_STAGES 2

`endif

// ==== rtl/valu_pkg.sv ====
`include "valu_defines.svh"

package valu_pkg;

  // one signed fixed-point element
  typedef logic signed [`VALU_ELEM_W-1:0] elem_t;

  // double-width product, sum or accumulator value
  typedef logic signed [2*`VALU_ELEM_W-1:0] acc_t;

  // lane 0 sits in the most significant position
  typedef elem_t [0:`VALU_NUM_ELEMS-1] vec_t;
  typedef acc_t [0:`VALU_NUM_ELEMS-1] acc_vec_t;

  typedef logic [0:`VALU_NUM_ELEMS-1] lane_mask_t;

  // lane condition
  typedef enum logic [1:0] {
    COND_NULL = 2'd0,
    COND_GT   = 2'd1,
    COND_LT   = 2'd2,
    COND_EQ   = 2'd3
  } cond_e;

  // compare result of one lane
  typedef struct packed {
    logic gt;
    logic lt;
    logic eq;
  } cmp_flags_t;

  // first three fields act at the input, the rest at accumulation
  typedef struct packed {
    logic  mult_by_one;
    logic  negate_b;
    cond_e cond;
    logic  add_to_zero;
    logic  saturate;
    logic  save_to_accum;
  } valu_ctrl_t;

endpackage

// ==== rtl/valu_product.sv ====
`include "valu_defines.svh"

module valu_product
  import valu_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  vec_t     i_a,
  input  vec_t     i_b,
  input  logic     i_mult_by_one,
  input  logic     i_negate_b,
  output acc_vec_t o_product
);

  localparam elem_t ONE = elem_t'(1);

  // operand stage
  vec_t a_q;
  vec_t b_q;
  logic neg_q;

  // multiplier output and its register stages
  acc_vec_t prod_d;
  acc_vec_t prod_pipe [`VALU_MULT_STAGES];

  // ------------------------------------------------
  // operand register
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    a_q <= i_a;
    for (int i = 0; i < `VALU_NUM_ELEMS; i++) begin
      // b replaced by unity for a plain move of a
      b_q[i] <= i_mult_by_one ? ONE : i_b[i];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      neg_q <= 1'b0;
    end else begin
      neg_q <= i_negate_b;
    end
  end

  // ------------------------------------------------
  // signed multiply per lane
  // ------------------------------------------------

  always_comb begin
    elem_t a_e;
    elem_t b_e;
    acc_t  p;
    for (int i = 0; i < `VALU_NUM_ELEMS; i++) begin
      a_e = a_q[i];
      b_e = b_q[i];
      // full signed product fits in acc_t even for -max * -max
      p = acc_t'(a_e) * acc_t'(b_e);
      prod_d[i] = neg_q ? -p : p;
    end
  end

  // multiplier pipeline
  always_ff @(posedge clk) begin
    prod_pipe[0] <= prod_d;
    for (int s = 1; s < `VALU_MULT_STAGES; s++) begin
      prod_pipe[s] <= prod_pipe[s-1];
    end
  end

  assign o_product = prod_pipe[`VALU_MULT_STAGES-1];

endmodule

// ==== rtl/valu_cond_track.sv ====
`include "valu_defines.svh"

module valu_cond_track
  import valu_pkg::*;
(
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_valid,
  input  valu_ctrl_t                          i_ctrl,
  input  cmp_flags_t [0:`VALU_NUM_ELEMS-1]    i_cmp,
  output logic                                o_valid,
  output lane_mask_t                          o_lane_en,
  output valu_ctrl_t                          o_ctrl
);

  // everything that rides along with one operation
  typedef struct packed {
    logic       valid;
    lane_mask_t lane_en;
    valu_ctrl_t ctrl;
  } track_t;

  // input stage that mirrors the operand register of the multiplier
  logic                             valid_q;
  valu_ctrl_t                       ctrl_q;
  cmp_flags_t [0:`VALU_NUM_ELEMS-1] cmp_q;

  lane_mask_t lane_en;
  track_t     pipe [`VALU_MULT_STAGES];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_q <= 1'b0;
      ctrl_q  <= '0;
      cmp_q   <= '0;
    end else begin
      valid_q <= i_valid;
      ctrl_q  <= i_ctrl;
      cmp_q   <= i_cmp;
    end
  end

  // ------------------------------------------------
  // condition decode
  // ------------------------------------------------

  always_comb begin
    for (int i = 0; i < `VALU_NUM_ELEMS; i++) begin
      unique case (ctrl_q.cond)
        COND_NULL: lane_en[i] = 1'b1;
        COND_GT:   lane_en[i] = cmp_q[i].gt;
        COND_LT:   lane_en[i] = cmp_q[i].lt;
        COND_EQ:   lane_en[i] = cmp_q[i].eq;
        default:   lane_en[i] = 1'b0;
      endcase
    end
  end

  // ------------------------------------------------
  // delay line alongside the products
  // ------------------------------------------------

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int s = 0; s < `VALU_MULT_STAGES; s++) begin
        pipe[s] <= '0;
      end
    end else begin
      pipe[0] <= '{valid: valid_q, lane_en: lane_en, ctrl: ctrl_q};
      for (int s = 1; s < `VALU_MULT_STAGES; s++) begin
        pipe[s] <= pipe[s-1];
      end
    end
  end

  assign o_valid   = pipe[`VALU_MULT_STAGES-1].valid;
  assign o_lane_en = pipe[`VALU_MULT_STAGES-1].lane_en;
  assign o_ctrl    = pipe[`VALU_MULT_STAGES-1].ctrl;

endmodule

// ==== rtl/valu_accumulate.sv ====
`include "valu_defines.svh"

module valu_accumulate
  import valu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       i_valid,
  input  lane_mask_t i_lane_en,
  input  valu_ctrl_t i_ctrl,
  input  acc_vec_t   i_product,
  output logic       o_valid,
  output vec_t       o_y,
  output lane_mask_t o_write_mask
);

  localparam int ACC_W = 2 * `VALU_ELEM_W;

  // clamp limits of the accumulator range
  localparam acc_t ACC_MAX = {1'b0, {(ACC_W-1){1'b1}}};
  localparam acc_t ACC_MIN = {1'b1, {(ACC_W-1){1'b0}}};

  // ------------------------------------------------
  // saturation helper
  // ------------------------------------------------

  // s is the wrapped sum p + q
  // overflow shows as differing carry into and out of the msb
  function automatic acc_t clamp_sum(acc_t p, acc_t q, acc_t s);
    logic cin;
    logic cout;
    acc_t rv;
    cin  = s[ACC_W-1] ^ p[ACC_W-1] ^ q[ACC_W-1];
    cout = (p[ACC_W-1] & q[ACC_W-1]) | (cin & (p[ACC_W-1] | q[ACC_W-1]));
    rv   = s;
    if (cout && !cin) begin
      // two negatives wrapped to positive
      rv = ACC_MIN;
    end else if (!cout && cin) begin
      rv = ACC_MAX;
    end
    return rv;
  endfunction

  acc_vec_t   acc_q;
  acc_vec_t   addend;
  acc_vec_t   sum;
  acc_vec_t   sat_sum;
  acc_vec_t   acc_d;
  vec_t       y_d;
  lane_mask_t acc_we;

  // ------------------------------------------------
  // adder and result select
  // ------------------------------------------------

  always_comb begin
    for (int i = 0; i < `VALU_NUM_ELEMS; i++) begin
      addend[i]  = i_ctrl.add_to_zero ? acc_t'(0) : acc_q[i];
      sum[i]     = i_product[i] + addend[i];
      sat_sum[i] = clamp_sum(i_product[i], addend[i], sum[i]);

      if (i_ctrl.saturate) begin
        // fractional result from the high half
        y_d[i]   = sat_sum[i][ACC_W-1 -: `VALU_ELEM_W];
        acc_d[i] = sat_sum[i];
      end else begin
        // modulo result
        y_d[i]   = sum[i][`VALU_ELEM_W-1:0];
        acc_d[i] = sum[i];
      end

      acc_we[i] = i_valid & i_ctrl.save_to_accum & i_lane_en[i];
    end
  end

  // ------------------------------------------------
  // accumulators and outputs
  // ------------------------------------------------

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      o_valid      <= 1'b0;
      o_write_mask <= '0;
      acc_q        <= '0;
    end else begin
      o_valid <= i_valid;
      if (i_valid) begin
        o_write_mask <= i_lane_en;
      end
      // masked lanes keep their accumulator
      for (int i = 0; i < `VALU_NUM_ELEMS; i++) begin
        if (acc_we[i]) begin
          acc_q[i] <= acc_d[i];
        end
      end
    end
  end

  // result holds between operations
  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_y <= y_d;
    end
  end

endmodule

// ==== rtl/valu_top.sv ====
`include "valu_defines.svh"

module valu_top
  import valu_pkg::*;
(
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             i_valid,
  input  valu_ctrl_t                       i_ctrl,
  input  cmp_flags_t [0:`VALU_NUM_ELEMS-1] i_cmp,
  input  vec_t                             i_a,
  input  vec_t                             i_b,
  output logic                             o_valid,
  output vec_t                             o_y,
  output lane_mask_t                       o_write_mask
);

  // all aligned with the products
  acc_vec_t   product;
  logic       acc_valid;
  lane_mask_t lane_en;
  valu_ctrl_t acc_ctrl;

  // ------------------------------------------------
  // multiply and condition tracking side by side
  // ------------------------------------------------

  valu_product i_product (
    .clk          (clk),
    .reset        (reset),
    .i_a          (i_a),
    .i_b          (i_b),
    .i_mult_by_one(i_ctrl.mult_by_one),
    .i_negate_b   (i_ctrl.negate_b),
    .o_product    (product)
  );

  valu_cond_track i_cond_track (
    .clk      (clk),
    .reset    (reset),
    .i_valid  (i_valid),
    .i_ctrl   (i_ctrl),
    .i_cmp    (i_cmp),
    .o_valid  (acc_valid),
    .o_lane_en(lane_en),
    .o_ctrl   (acc_ctrl)
  );

  // ------------------------------------------------
  // accumulate stage
  // ------------------------------------------------

  valu_accumulate i_accumulate (
    .clk         (clk),
    .reset       (reset),
    .i_valid     (acc_valid),
    .i_lane_en   (lane_en),
    .i_ctrl      (acc_ctrl),
    .i_product   (product),
    .o_valid     (o_valid),
    .o_y         (o_y),
    .o_write_mask(o_write_mask)
  );

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock (
  output logic o_clk
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PERIOD_NS = 4;

  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) o_clk = ~o_clk;
    end
  end

endmodule

// ==== bench/tb_valu.sv ====
`include "valu_defines.svh"

module tb_valu
  import valu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_REC       = 29;
  localparam int REC_W         = 216;
  localparam int RESET_CYCLES  = 8;
  localparam int DRIVE_DELAY   = 1;
  localparam int DRAIN_TIMEOUT = 40;
  // edges from sampling an operation to the edge that raises o_valid
  localparam int LATENCY       = 3;

  // one line of the pattern file
  typedef struct packed {
    logic [7:0]                   ctrl;
    logic [3*`VALU_NUM_ELEMS-1:0] cmp;
    lane_mask_t                   mask;
    vec_t                         a;
    vec_t                         b;
    vec_t                         y;
  } pattern_t;

  // result the DUT still owes
  typedef struct packed {
    logic [31:0] rec;
    logic [31:0] sample_cycle;
    vec_t        y;
    lane_mask_t  mask;
  } expect_t;

  logic                             clk;
  logic                             reset;
  logic                             op_valid;
  valu_ctrl_t                       op_ctrl;
  cmp_flags_t [0:`VALU_NUM_ELEMS-1] op_cmp;
  vec_t                             op_a;
  vec_t                             op_b;
  logic                             res_valid;
  vec_t                             res_y;
  lane_mask_t                       res_mask;

  logic [REC_W-1:0] patterns [NUM_REC];
  expect_t          expect_q [$];
  int               checks = 0;
  int               value_errors = 0;
  int               other_errors = 0;
  int               results_seen = 0;
  int               cycle_count = 0;

  tb_clock i_clock (.o_clk(clk));

  valu_top i_dut (
    .clk         (clk),
    .reset       (reset),
    .i_valid     (op_valid),
    .i_ctrl      (op_ctrl),
    .i_cmp       (op_cmp),
    .i_a         (op_a),
    .i_b         (op_b),
    .o_valid     (res_valid),
    .o_y         (res_y),
    .o_write_mask(res_mask)
  );

  // rising edges seen so far
  always @(posedge clk) begin
    cycle_count++;
  end

  // ------------------------------------------------
  // stimulus
  // ------------------------------------------------

  task automatic load_patterns();
    pattern_t p;
    for (int i = 0; i < NUM_REC; i++) begin
      // top byte marks a record the file left empty
      patterns[i] = {8'hff, (REC_W-8)'(i)};
    end
    $readmemh("bench/valu_patterns.hex", patterns);
    for (int i = 0; i < NUM_REC; i++) begin
      p = pattern_t'(patterns[i]);
      assert (p.ctrl[7] == 1'b0) else begin
        $display("pattern record %0d is missing from the pattern file", i);
        other_errors++;
      end
    end
  endtask

  task automatic drive_record(input int idx);
    pattern_t p;
    expect_t  e;
    p = pattern_t'(patterns[idx]);
    @(posedge clk);
    #DRIVE_DELAY;
    op_valid = 1'b1;
    op_ctrl  = valu_ctrl_t'(p.ctrl[6:0]);
    op_cmp   = p.cmp;
    op_a     = p.a;
    op_b     = p.b;
    e.rec    = idx;
    // the next rising edge samples this operation
    e.sample_cycle = cycle_count + 1;
    e.y      = p.y;
    e.mask   = p.mask;
    expect_q.push_back(e);
  endtask

  task automatic wait_for_drain();
    int cycles;
    cycles = 0;
    while (expect_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    assert (expect_q.size() == 0) else begin
      $display("timeout: record %0d never produced o_valid within %0d cycles",
               expect_q[0].rec, DRAIN_TIMEOUT);
      other_errors++;
    end
  endtask

  task automatic report_and_finish();
    $display("checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  initial begin
    op_valid = 1'b0;
    op_ctrl  = '0;
    op_cmp   = '0;
    op_a     = '0;
    op_b     = '0;
    reset    = 1'b1;
    load_patterns();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    // a few idle cycles with outputs at their reset values
    repeat (3) @(posedge clk);
    for (int i = 0; i < NUM_REC; i++) begin
      drive_record(i);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    op_valid = 1'b0;
    wait_for_drain();
    // stray pulses after the last result
    repeat (4) @(posedge clk);
    report_and_finish();
  end

  // ------------------------------------------------
  // result checking on the falling clock edge
  // ------------------------------------------------

  always @(negedge clk) begin : check_results
    expect_t front;
    int      latency;
    if (res_valid) begin
      assert (expect_q.size() != 0) else begin
        $display("o_valid pulsed with no operation outstanding");
        other_errors++;
      end
      if (expect_q.size() != 0) begin
        front = expect_q.pop_front();
        latency = cycle_count - int'(front.sample_cycle);
        assert (latency == LATENCY) else begin
          $display("record %0d: o_valid came %0d cycles after the operation instead of %0d",
                   front.rec, latency, LATENCY);
          other_errors++;
        end
        assert (res_y == front.y) else begin
          $display("[ERROR] o_y record %0d: got %h expected %h", front.rec, res_y, front.y);
          value_errors++;
        end
        assert (res_mask == front.mask) else begin
          $display("[ERROR] o_write_mask record %0d: got %h expected %h",
                   front.rec, res_mask, front.mask);
          value_errors++;
        end
        checks += 3;
        results_seen++;
      end
    end else if (results_seen == 0) begin
      // reset value holds until the first result
      assert (res_mask == '0) else begin
        $display("[ERROR] o_write_mask before first result: got %h expected %h",
                 res_mask, 4'h0);
        value_errors++;
      end
      checks++;
    end
  end

endmodule

// ==== tb.f ====
+incdir+include
rtl/valu_pkg.sv
rtl/valu_product.sv
rtl/valu_cond_track.sv
rtl/valu_accumulate.sv
rtl/valu_top.sv
bench/tb_clock.sv
bench/tb_valu.sv

// ==== Makefile ====
# Verilator build and run of the vector MAC testbench

VERILATOR ?= verilator
TOP       ?= tb_valu
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= All checks passed

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, not the exit status of the binary
run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

check: run
	@echo "simulation passed, log in $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/valu_patterns.hex ====
// columns: ctrl_cmp_mask_a(lane0..3)_b(lane0..3)_y(lane0..3), lane 0 first
// ctrl = {0,mult_by_one,negate_b,cond[1:0],add_to_zero,saturate,save_to_accum}
// fresh accumulators read as zero
40_000_f_1111_2222_3333_4444_dead_beef_dead_beef_1111_2222_3333_4444
42_000_f_7fff_8000_0001_ffff_0000_0000_0000_0000_0000_ffff_0000_ffff
// plain products, modulo result
04_000_f_0003_fffe_0100_7fff_0005_0007_0100_7fff_000f_fff2_0000_0001
44_000_f_1234_8001_0000_abcd_9999_9999_9999_9999_1234_8001_0000_abcd
24_000_f_0003_fffe_0100_8000_0005_0007_0003_0001_fff1_000e_fd00_8000
64_000_f_0001_7fff_8000_0000_5555_5555_5555_5555_ffff_8001_8000_0000
// most negative squared, then clamped on the high half
07_000_f_8000_8000_8000_8000_8000_8000_8000_8000_4000_4000_4000_4000
02_000_f_8000_8000_8000_8000_8000_8000_8000_8000_7fff_7fff_7fff_7fff
45_000_f_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000
// back to back accumulation
01_000_f_0002_0010_ffff_0100_0003_0010_0005_0100_0006_0100_fffb_0000
01_000_f_0004_fff0_0003_0100_0005_0010_0003_0100_001a_0000_0004_0000
41_000_f_0001_7fff_fffc_0001_0000_0000_0000_0000_001b_7fff_0000_0001
42_000_f_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0002
// lane conditions gt, lt, eq, then readback
49_8a1_a_0005_0005_0005_0005_0000_0000_0000_0000_0020_8004_0005_0006
51_8a1_4_0001_0001_0001_0001_0000_0000_0000_0000_0021_8000_0006_0002
59_261_d_0002_0002_0002_0002_0000_0000_0000_0000_0022_8002_0007_0003
40_000_f_0000_0000_0000_0000_0000_0000_0000_0000_0022_8002_0005_0003
// saturating accumulation holds at the maximum
05_000_f_8000_8000_8000_8000_8000_8000_8000_8000_0000_0000_0000_0000
03_000_f_8000_8000_8000_8000_8000_8000_8000_8000_7fff_7fff_7fff_7fff
03_000_f_8000_8000_8000_8000_8000_8000_8000_8000_7fff_7fff_7fff_7fff
03_000_f_0001_0001_0001_0001_0001_0001_0001_ffff_7fff_7fff_7fff_7fff
40_000_f_0000_0000_0000_0000_0000_0000_0000_0000_ffff_ffff_ffff_fffe
// same sequence without saturate wraps negative
05_000_f_8000_8000_8000_8000_8000_8000_8000_8000_0000_0000_0000_0000
01_000_f_8000_8000_8000_8000_8000_8000_8000_8000_0000_0000_0000_0000
01_000_f_8000_8000_8000_8000_8000_8000_8000_8000_0000_0000_0000_0000
42_000_f_0000_0000_0000_0000_0000_0000_0000_0000_c000_c000_c000_c000
// negated products clamp at the minimum
23_000_f_8000_8000_8000_8000_8000_8000_8000_8000_8000_8000_8000_8000
23_000_f_8000_8000_8000_8000_8000_8000_8000_8000_8000_8000_8000_8000
45_000_f_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000
